// ==== lcd_settings.svh ====
`ifndef LCD_SETTINGS_SVH
`define LCD_SETTINGS_SVH

// read timing in pclk cycles
// each phase lasts one cycle longer than the value given here

// id register read, short timing
`define LCD_RD_ID_L 3       // rd low (setup)
`define LCD_RD_ID_H 5       // rd high (hold)

// frame memory read, long timing
`define LCD_RD_FM_L 8       // rd low (setup)
`define LCD_RD_FM_H 13      // rd high (hold)

// read cycles per command
`define LCD_SINGLE_READS 1
`define LCD_COLOR_READS 2   // one pixel takes two bus reads

// counter widths inside the bus engine
// delay width must hold the largest of the four timing values
`define LCD_DELAY_W 4
`define LCD_READ_W 2

`endif

// ==== lcd_pkg.sv ====
package lcd_pkg;

    // host command opcodes
    // codes 5..7 are not assigned and get rejected by the decoder
    typedef enum logic [2:0] {
        CMD_WR_INST  = 3'd0,   // one write, rs low
        CMD_WR_DATA  = 3'd1,   // one write, rs high
        CMD_RD_ID    = 3'd2,   // address write + short read
        CMD_RD_FM    = 3'd3,   // address write + long read
        CMD_RD_COLOR = 3'd4    // address write + two long reads
    } lcd_cmd_e;

    // bus engine states
    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_SETUP_WRITE = 3'd1,  // wr low, data driven
        ST_WRITING     = 3'd2,  // wr high, data held
        ST_SETUP_READ  = 3'd3,  // rd low
        ST_READING     = 3'd4   // rd high, sample taken on entry
    } lcd_state_e;

endpackage

// ==== lcd_req_if.sv ====
`timescale 1ns/1ps

// one bus request from the decoder to the engine
interface lcd_req_if;

    logic        we;           // start pulse
    logic        rs;           // 0 inst, 1 data
    logic        wr_only;      // no read after the write
    logic        fm_sel;       // 0 id timing, 1 frame memory timing
    logic        color;        // two reads instead of one
    logic [15:0] wdata;

    logic        engine_busy;  // level, engine not idle
    logic        write_ok;     // pulse when the write starts

    modport decoder (
        output we, rs, wr_only, fm_sel, color, wdata,
        input  engine_busy, write_ok
    );

    modport engine (
        input  we, rs, wr_only, fm_sel, color, wdata,
        output engine_busy, write_ok
    );

endinterface

// ==== lcd_cmd_decode.sv ====
`timescale 1ns/1ps

module lcd_cmd_decode
    import lcd_pkg::*;
(
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        cmd_valid_i,
    input  lcd_cmd_e    cmd_op_i,
    input  logic [15:0] cmd_data_i,
    output logic        busy_o,
    output logic        cmd_err_o,
    lcd_req_if.decoder  req
);

    logic legal;
    logic accept;
    logic pending;       // request issued, engine not yet busy
    logic dec_rs;
    logic dec_wr_only;
    logic dec_fm_sel;
    logic dec_color;

    // opcode to request fields
    always_comb begin
        legal       = 1'b1;
        dec_rs      = 1'b0;
        dec_wr_only = 1'b0;
        dec_fm_sel  = 1'b0;
        dec_color   = 1'b0;
        case (cmd_op_i)
            CMD_WR_INST: dec_wr_only = 1'b1;
            CMD_WR_DATA: begin
                dec_rs      = 1'b1;
                dec_wr_only = 1'b1;
            end
            CMD_RD_ID:   dec_fm_sel = 1'b0;   // short timing
            CMD_RD_FM:   dec_fm_sel = 1'b1;
            CMD_RD_COLOR: begin
                dec_fm_sel = 1'b1;
                dec_color  = 1'b1;
            end
            default:     legal = 1'b0;
        endcase
    end

    assign accept = cmd_valid_i && legal && !busy_o;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            req.we    <= 1'b0;
            pending   <= 1'b0;
            busy_o    <= 1'b0;
            cmd_err_o <= 1'b0;
        end else begin
            req.we    <= accept;
            if (accept)
                pending <= 1'b1;
            else if (req.write_ok)
                pending <= 1'b0;   // engine has taken it
            busy_o    <= accept || pending || req.engine_busy;
            cmd_err_o <= cmd_valid_i && !accept;   // illegal or overlapping
        end
    end

    // fields only change on accept, so they stay put while the engine runs
    always_ff @(posedge pclk) begin
        if (accept) begin
            req.rs      <= dec_rs;
            req.wr_only <= dec_wr_only;
            req.fm_sel  <= dec_fm_sel;
            req.color   <= dec_color;
            req.wdata   <= cmd_data_i;
        end
    end

endmodule

// ==== lcd_bus_engine.sv ====
`timescale 1ns/1ps
`include "lcd_settings.svh"

module lcd_bus_engine
    import lcd_pkg::*;
(
    input  logic        pclk,
    input  logic        rst_n,
    lcd_req_if.engine   req,
    output logic        lcd_cs_o,
    output logic        lcd_rs_o,
    output logic        lcd_wr_o,
    output logic        lcd_rd_o,
    input  logic [15:0] lcd_data_i,
    output logic [15:0] lcd_data_o,
    output logic        lcd_data_oe_o,
    output logic        lcd_bl_o,
    output logic        lcd_rst_o,
    output logic        sample_valid_o,
    output logic [15:0] sample_o,
    output logic        read_done_o
);

    lcd_state_e state;
    lcd_state_e next_state;

    logic [`LCD_DELAY_W-1:0] time_cnt;    // cycles spent in the current phase
    logic [`LCD_DELAY_W-1:0] delay_time;  // last count of the current phase
    logic [`LCD_READ_W-1:0]  read_cnt;    // reads started so far
    logic [`LCD_READ_W-1:0]  read_num;    // reads wanted
    logic                    phase_end;
    logic                    last_read;

    assign phase_end = (time_cnt == delay_time);
    assign last_read = (read_cnt == read_num);

    // backlight on right after reset, panel reset follows ours
    always_ff @(posedge pclk) begin
        if (!rst_n)
            lcd_bl_o <= 1'b0;
        else
            lcd_bl_o <= 1'b1;
    end

    assign lcd_rst_o = rst_n;

    always_ff @(posedge pclk) begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:        if (req.we) next_state = ST_SETUP_WRITE;
            ST_SETUP_WRITE: next_state = ST_WRITING;
            ST_WRITING:     next_state = req.wr_only ? ST_IDLE : ST_SETUP_READ;
            ST_SETUP_READ:  if (phase_end) next_state = ST_READING;
            ST_READING: begin
                if (phase_end)
                    next_state = last_read ? ST_IDLE : ST_SETUP_READ;
            end
            default:        next_state = ST_IDLE;
        endcase
    end

    assign req.engine_busy = (state != ST_IDLE);
    assign req.write_ok    = (state == ST_IDLE) && req.we;

    // phase length is loaded as the phase is entered
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            delay_time <= '0;
        end else begin
            case (next_state)
                ST_SETUP_READ: delay_time <= req.fm_sel ? `LCD_DELAY_W'(`LCD_RD_FM_L)
                                                        : `LCD_DELAY_W'(`LCD_RD_ID_L);
                ST_READING:    delay_time <= req.fm_sel ? `LCD_DELAY_W'(`LCD_RD_FM_H)
                                                        : `LCD_DELAY_W'(`LCD_RD_ID_H);
                default:       delay_time <= '0;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n)
            time_cnt <= '0;
        else if ((state == ST_SETUP_READ || state == ST_READING) && !phase_end)
            time_cnt <= time_cnt + 1'b1;
        else
            time_cnt <= '0;   // wraps at each phase change
    end

    // read count is fixed when the first read phase starts
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            read_num <= '0;
            read_cnt <= '0;
        end else if (state == ST_WRITING) begin
            read_num <= req.color ? `LCD_READ_W'(`LCD_COLOR_READS)
                                  : `LCD_READ_W'(`LCD_SINGLE_READS);
            read_cnt <= '0;
        end else if (state == ST_SETUP_READ && phase_end) begin
            read_cnt <= read_cnt + 1'b1;   // counted on the way into READING
        end
    end

    // panel data is sampled as rd rises
    always_ff @(posedge pclk) begin
        if (state == ST_SETUP_READ && phase_end)
            sample_o <= lcd_data_i;
    end

    assign sample_valid_o = (state == ST_READING) && phase_end;
    assign read_done_o    = sample_valid_o && last_read;

    // pins follow the state being entered
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            lcd_cs_o      <= 1'b1;
            lcd_rs_o      <= 1'b0;
            lcd_wr_o      <= 1'b1;
            lcd_rd_o      <= 1'b1;
            lcd_data_oe_o <= 1'b0;
        end else begin
            lcd_cs_o      <= (next_state == ST_IDLE);
            lcd_wr_o      <= (next_state != ST_SETUP_WRITE);
            lcd_rd_o      <= (next_state != ST_SETUP_READ);
            lcd_data_oe_o <= (next_state == ST_SETUP_WRITE) || (next_state == ST_WRITING);
            case (next_state)
                ST_SETUP_WRITE, ST_WRITING: lcd_rs_o <= req.rs;
                ST_SETUP_READ, ST_READING:  lcd_rs_o <= 1'b1;
                default:                    lcd_rs_o <= 1'b0;
            endcase
        end
    end

    // write word held through WRITING and kept afterwards
    always_ff @(posedge pclk) begin
        if (next_state == ST_SETUP_WRITE)
            lcd_data_o <= req.wdata;
    end

endmodule

// ==== lcd_read_collect.sv ====
`timescale 1ns/1ps

module lcd_read_collect (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        sample_valid_i,
    input  logic [15:0] sample_i,
    input  logic        read_done_i,
    output logic [31:0] rd_data_o,
    output logic        rd_valid_o
);

    logic [31:0] acc;
    logic [31:0] acc_next;

    // first sample moves up as later ones arrive
    always_comb begin
        acc_next = acc;
        if (sample_valid_i)
            acc_next = {acc[15:0], sample_i};
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (read_done_i) begin
            acc <= '0;   // start clean for the next command
        end else begin
            acc <= acc_next;
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            rd_data_o  <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= read_done_i;
            if (read_done_i)
                rd_data_o <= acc_next;   // includes the last sample
        end
    end

endmodule

// ==== lcd_subsys_top.sv ====
`timescale 1ns/1ps

module lcd_subsys_top
    import lcd_pkg::*;
(
    input  logic        pclk,
    input  logic        rst_n,

    // host side
    input  logic        cmd_valid_i,
    input  lcd_cmd_e    cmd_op_i,
    input  logic [15:0] cmd_data_i,
    output logic        busy_o,
    output logic        cmd_err_o,

    // panel side
    output logic        lcd_cs_o,
    output logic        lcd_rs_o,
    output logic        lcd_wr_o,
    output logic        lcd_rd_o,
    input  logic [15:0] lcd_data_i,
    output logic [15:0] lcd_data_o,
    output logic        lcd_data_oe_o,   // pad drives lcd_data_o when high
    output logic        lcd_bl_o,
    output logic        lcd_rst_o,

    // read result
    output logic [31:0] rd_data_o,
    output logic        rd_valid_o
);

    logic        sample_valid;
    logic [15:0] sample;
    logic        read_done;

    lcd_req_if req_if ();

    lcd_cmd_decode i_lcd_cmd_decode (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_op_i    (cmd_op_i),
        .cmd_data_i  (cmd_data_i),
        .busy_o      (busy_o),
        .cmd_err_o   (cmd_err_o),
        .req         (req_if.decoder)
    );

    lcd_bus_engine i_lcd_bus_engine (
        .pclk           (pclk),
        .rst_n          (rst_n),
        .req            (req_if.engine),
        .lcd_cs_o       (lcd_cs_o),
        .lcd_rs_o       (lcd_rs_o),
        .lcd_wr_o       (lcd_wr_o),
        .lcd_rd_o       (lcd_rd_o),
        .lcd_data_i     (lcd_data_i),
        .lcd_data_o     (lcd_data_o),
        .lcd_data_oe_o  (lcd_data_oe_o),
        .lcd_bl_o       (lcd_bl_o),
        .lcd_rst_o      (lcd_rst_o),
        .sample_valid_o (sample_valid),
        .sample_o       (sample),
        .read_done_o    (read_done)
    );

    lcd_read_collect i_lcd_read_collect (
        .pclk           (pclk),
        .rst_n          (rst_n),
        .sample_valid_i (sample_valid),
        .sample_i       (sample),
        .read_done_i    (read_done),
        .rd_data_o      (rd_data_o),
        .rd_valid_o     (rd_valid_o)
    );

endmodule

// ==== lcd_sva.sv ====
`timescale 1ns/1ps

module lcd_sva
    import lcd_pkg::*;
(
    input logic       pclk,
    input logic       rst_n,
    input lcd_state_e state_i,
    input logic       lcd_cs_i,
    input logic       lcd_wr_i,
    input logic       lcd_rd_i,
    input logic       data_oe_i,
    input logic       sample_valid_i
);

    int fail_cnt = 0;   // failed assertions so far

    strobes_exclusive: assert property (@(posedge pclk) disable iff (!rst_n)
        !(!lcd_wr_i && !lcd_rd_i))
        else begin
            $error("lcd_wr_o and lcd_rd_o low together");
            fail_cnt++;
        end

    // any strobe needs the chip selected
    cs_with_strobe: assert property (@(posedge pclk) disable iff (!rst_n)
        (!lcd_wr_i || !lcd_rd_i) |-> !lcd_cs_i)
        else begin
            $error("strobe low while lcd_cs_o high");
            fail_cnt++;
        end

    oe_in_write: assert property (@(posedge pclk) disable iff (!rst_n)
        data_oe_i |-> (!lcd_wr_i || state_i == ST_WRITING))
        else begin
            $error("lcd_data_oe_o high outside a write cycle");
            fail_cnt++;
        end

    sample_in_reading: assert property (@(posedge pclk) disable iff (!rst_n)
        sample_valid_i |-> (state_i == ST_READING))
        else begin
            $error("sample_valid_o outside ST_READING");
            fail_cnt++;
        end

endmodule

bind lcd_bus_engine lcd_sva i_lcd_sva (
    .pclk           (pclk),
    .rst_n          (rst_n),
    .state_i        (state),
    .lcd_cs_i       (lcd_cs_o),
    .lcd_wr_i       (lcd_wr_o),
    .lcd_rd_i       (lcd_rd_o),
    .data_oe_i      (lcd_data_oe_o),
    .sample_valid_i (sample_valid_o)
);

// ==== tb_lcd_subsys.sv ====
`timescale 1ns/1ps
`include "lcd_settings.svh"

module tb_lcd_subsys
    import lcd_pkg::*;
();

    localparam int CLK_PERIOD = 8;

    logic        pclk = 1'b0;
    logic        rst_n;
    logic        cmd_valid_i;
    lcd_cmd_e    cmd_op_i;
    logic [15:0] cmd_data_i;
    logic [15:0] lcd_data_i;
    logic        busy_o, cmd_err_o, rd_valid_o;
    logic        lcd_cs_o, lcd_rs_o, lcd_wr_o, lcd_rd_o;
    logic        lcd_data_oe_o, lcd_bl_o, lcd_rst_o;
    logic [15:0] lcd_data_o;
    logic [31:0] rd_data_o;

    // one entry per command line of the data file
    logic [2:0]  t_op[$];
    logic [15:0] t_word[$], t_p0[$], t_p1[$];
    logic [31:0] t_exp[$];
    logic        t_busy[$];
    int          n_cmds = 0;

    // bus monitor state
    logic        mon_en;
    logic        prev_wr, prev_rd;
    int          n_wr = 0, n_rd = 0, n_valid = 0, n_err = 0;
    int          rd_len = 0, rd_len_exp = 0;
    logic        wr_rs;
    logic [15:0] wr_data, p0, p1;
    logic [31:0] last_rd;

    lcd_subsys_top i_lcd_subsys_top (.*);

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("Mismatch at %0t: %s", $time, what));
    endtask

    task automatic load_tests();
        int               fd;
        int               n;
        logic [2:0]       op;
        logic [15:0]      word, w0, w1;
        logic [31:0]      exp;
        logic             busy_flag;
        logic [8*160-1:0] line;
        fd = $fopen("lcd_testdata.txt", "r");
        if (fd == 0)
            abort_run("could not open lcd_testdata.txt");
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            if (n > 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h", op, word, w0, w1, exp, busy_flag);
                if (n == 6) begin
                    t_op.push_back(op);
                    t_word.push_back(word);
                    t_p0.push_back(w0);
                    t_p1.push_back(w1);
                    t_exp.push_back(exp);
                    t_busy.push_back(busy_flag);
                end else if (n > 0) begin
                    abort_run("lcd_testdata.txt holds a line with missing columns");
                end
            end
        end
        $fclose(fd);
        if (t_op.size() == 0)
            abort_run("lcd_testdata.txt holds no commands");
        n_cmds = t_op.size();
    endtask

    task automatic run_command(input int i);
        logic legal;
        logic is_rd;
        int   n_rd_exp;
        legal    = (t_op[i] <= CMD_RD_COLOR);
        is_rd    = legal && (t_op[i] >= CMD_RD_ID);
        n_rd_exp = (t_op[i] == CMD_RD_COLOR) ? `LCD_COLOR_READS : (is_rd ? 1 : 0);
        // first panel word on top for a color read, zero extended otherwise
        if (is_rd && t_exp[i] != ((t_op[i] == CMD_RD_COLOR) ? {t_p0[i], t_p1[i]}
                                                            : {16'h0, t_p0[i]}))
            abort_run($sformatf("entry %0d of lcd_testdata.txt has a wrong expected result", i));
        n_wr    = 0;
        n_rd    = 0;
        n_valid = 0;
        n_err   = 0;
        p0      = t_p0[i];
        p1      = t_p1[i];
        rd_len_exp  = (t_op[i] == CMD_RD_ID) ? (`LCD_RD_ID_L + 1) : (`LCD_RD_FM_L + 1);
        cmd_valid_i = 1'b1;
        cmd_op_i    = lcd_cmd_e'(t_op[i]);
        cmd_data_i  = t_word[i];
        @(negedge pclk);
        assert (cmd_err_o == !legal && busy_o == legal)
            else report_mismatch($sformatf("entry %0d busy=%b err=%b after strobe", i,
                                           busy_o, cmd_err_o));
        cmd_valid_i = legal && t_busy[i];   // extra strobe while busy
        cmd_op_i    = CMD_WR_DATA;
        cmd_data_i  = ~t_word[i];
        @(negedge pclk);
        cmd_valid_i = 1'b0;
        assert (cmd_err_o == (legal && t_busy[i]))
            else report_mismatch($sformatf("entry %0d busy strobe err=%b", i, cmd_err_o));
        while (busy_o)
            @(negedge pclk);
        repeat (2) @(negedge pclk);
        assert (n_err == (legal ? int'(t_busy[i]) : 1) && n_wr == int'(legal))
            else report_mismatch($sformatf("entry %0d errors=%0d writes=%0d", i, n_err, n_wr));
        if (legal)
            assert (wr_rs == (t_op[i] == CMD_WR_DATA) && wr_data == t_word[i])
                else report_mismatch($sformatf("entry %0d write rs=%b data=%h", i,
                                               wr_rs, wr_data));
        assert (n_rd == n_rd_exp && n_valid == int'(is_rd))
            else report_mismatch($sformatf("entry %0d reads=%0d results=%0d", i, n_rd, n_valid));
        if (is_rd)
            assert (last_rd == t_exp[i])
                else report_mismatch($sformatf("entry %0d rd_data %h, expected %h", i,
                                               last_rd, t_exp[i]));
    endtask

    initial begin
        forever #(CLK_PERIOD / 2) pclk = ~pclk;
    end

    // budget per command covers two long reads plus decoder overhead
    initial begin
        wait (n_cmds > 0);
        #((n_cmds * (2 * (`LCD_RD_FM_L + `LCD_RD_FM_H + 2) + 10) + 20) * CLK_PERIOD);
        abort_run("Timeout: the command list did not complete in time");
    end

    always @(i_lcd_subsys_top.i_lcd_bus_engine.i_lcd_sva.fail_cnt) begin
        if (i_lcd_subsys_top.i_lcd_bus_engine.i_lcd_sva.fail_cnt != 0)
            abort_run("a pin protocol assertion on the bus engine failed");
    end

    // pin monitor and panel model, sampled away from the rising edge
    always @(negedge pclk) begin
        if (mon_en) begin
            if (!prev_wr && lcd_wr_o) begin
                $display("wr rise at %0t: rs=%b data=%h", $time, lcd_rs_o, lcd_data_o);
                assert (!lcd_cs_o && lcd_data_oe_o)
                    else report_mismatch("cs high or data enable low at wr rising edge");
                n_wr++;
                wr_rs   = lcd_rs_o;
                wr_data = lcd_data_o;
            end
            if (!lcd_rd_o) begin
                if (prev_rd) begin
                    lcd_data_i = (n_rd == 0) ? p0 : p1;   // panel answers the read
                    n_rd++;
                    rd_len = 0;
                end
                rd_len++;
            end else if (!prev_rd) begin
                assert (rd_len == rd_len_exp)
                    else report_mismatch($sformatf("rd low for %0d cycles, expected %0d",
                                                   rd_len, rd_len_exp));
            end
            if (rd_valid_o) begin
                n_valid++;
                last_rd = rd_data_o;
            end
            if (cmd_err_o)
                n_err++;
        end
        prev_wr = lcd_wr_o;
        prev_rd = lcd_rd_o;
    end

    initial begin
        rst_n       = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_op_i    = CMD_WR_INST;
        cmd_data_i  = '0;
        lcd_data_i  = '0;
        mon_en      = 1'b0;
        load_tests();
        repeat (8) @(negedge pclk);
        assert (lcd_cs_o && lcd_wr_o && lcd_rd_o && !lcd_rs_o && !lcd_data_oe_o && !lcd_bl_o
                && !lcd_rst_o)
            else report_mismatch("bus pins not idle during reset");
        rst_n = 1'b1;
        repeat (2) @(negedge pclk);
        assert (lcd_bl_o && lcd_rst_o && lcd_cs_o && lcd_wr_o && lcd_rd_o && !busy_o
                && !rd_valid_o && !cmd_err_o)
            else report_mismatch("outputs not idle after reset release");
        mon_en = 1'b1;
        foreach (t_op[i])
            run_command(i);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== lcd_testdata.txt ====
# columns (hex): opcode command_word panel_word0 panel_word1 expected_result busy_issue
# opcode 0 wr inst, 1 wr data, 2 rd id, 3 rd fm, 4 rd color, 5..7 illegal
0 0036 0000 0000 00000000 0
1 00a8 0000 0000 00000000 0
2 0004 8552 0000 00008552 0
3 002e 1a2b 0000 00001a2b 0
4 002e beef cafe beefcafe 0
1 1234 0000 0000 00000000 1
2 00da 5a5a 0000 00005a5a 1
6 0000 0000 0000 00000000 0
3 0000 ffff 0000 0000ffff 1
4 0c3c 0001 8000 00018000 1
7 ffff 0000 0000 00000000 0
0 ffff 0000 0000 00000000 1
5 0011 0000 0000 00000000 0
2 00dc 0000 0000 00000000 0
4 002e 0000 ffff 0000ffff 0
3 a5a5 c3c3 0000 0000c3c3 0

// ==== list.f ====
+incdir+.
lcd_pkg.sv
lcd_req_if.sv
lcd_cmd_decode.sv
lcd_bus_engine.sv
lcd_read_collect.sv
lcd_subsys_top.sv
lcd_sva.sv
tb_lcd_subsys.sv
